//--- common/cascade_settings.svh
// ----------------------------------------------------------------------
// cascade reconciliation sizing for the Alice side
// ----------------------------------------------------------------------
`ifndef CASCADE_SETTINGS_SVH
`define CASCADE_SETTINGS_SVH

// frame key and sifted-key RAM
`define KEY_LEN        256
`define RAM_W          64
`define KEY_RAM_WORDS  4
`define RAM_ADDR_W     15
`define ROUND_W        12

// packet words and header count field
`define FIFO_W         32
`define HDR_CNT_W      9

// rows 1..4 hold parities over blocks of 1, 2, 4 and 8 bits
`define TREE_ROWS      4
`define ERR_W          10

`endif

//--- common/cascade_pkg.sv
// ----------------------------------------------------------------------
// cascade packet header, controller strobes and encodings
// ----------------------------------------------------------------------
`include "cascade_settings.svh"

package cascade_pkg;

    // bit 2 marks a top-level packet
    typedef enum logic [2:0] {
        PT_NORMAL      = 3'b000,
        PT_TOP_CORRECT = 3'b001,
        PT_TOP_MESSAGE = 3'b100,
        PT_FIRST_TOP   = 3'b101,
        PT_TOP_COMPARE = 3'b110
    } parity_type_e;

    typedef enum logic [3:0] {
        MSG_B2A_ASK    = 4'd1,
        MSG_A2B_PARITY = 4'd2
    } msg_type_e;

    typedef enum logic [3:0] {
        CASCADE_IDLE,
        LOADKEY,
        IDLE,
        READ_HEADER,
        WRITE_HEADER,
        REPLY,
        SETTLE,
        CLOSE,
        FINISH,
        FRAME_OUT,
        CASCADE_END
    } ctrl_state_e;

    // one FIFO word, msb first
    typedef struct packed {
        logic [3:0]            msg;
        logic [3:0]            len_code;
        logic [`HDR_CNT_W-1:0] count;
        logic [2:0]            ptype;
        logic [2:0]            shuffle_set;
        logic [3:0]            tree_row;
        logic [4:0]            frame_id;
    } cascade_hdr_t;

    typedef struct packed {
        logic load_en;
        logic read_hdr;
        logic write_hdr;
        logic reply_en;
        logic close_hdr;
        logic clear_round;
    } ctrl_cmd_t;

endpackage

//--- design/key_loader.sv
// ----------------------------------------------------------------------
// frame key loader, reads the sifted-key RAM into the key register
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "cascade_settings.svh"

module key_loader (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cascade_pkg::ctrl_cmd_t cmd_i,
    input  logic [`ROUND_W-1:0]    frame_round_i,
    input  logic                   addr_bank_i,
    output logic [`RAM_ADDR_W-1:0] key_addr_o,
    input  logic [`RAM_W-1:0]      key_data_i,
    output logic                   load_done_o,
    output logic [`KEY_LEN-1:0]    frame_key_o
);

    localparam int WIDX_W = $clog2(`KEY_RAM_WORDS);
    localparam int CNT_W  = $clog2(`KEY_RAM_WORDS + 2);

    logic [CNT_W-1:0]  load_cnt;
    logic [`RAM_W-1:0] data_q;
    logic              shift_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_cnt <= '0;
        end else if (cmd_i.load_en) begin
            load_cnt <= load_cnt + 1'b1;
        end else begin
            load_cnt <= '0;
        end
    end

    // low bits step through the words of this frame
    assign key_addr_o = {addr_bank_i, frame_round_i, load_cnt[WIDX_W-1:0]};

    // RAM read latency plus the capture register
    always_ff @(posedge clk) begin
        data_q <= key_data_i;
    end

    assign shift_en = cmd_i.load_en && (load_cnt >= CNT_W'(2));

    // first word ends up at the msb end
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_key_o <= '0;
        end else if (shift_en) begin
            frame_key_o <= {frame_key_o[`KEY_LEN-`RAM_W-1:0], data_q};
        end
    end

    // last word shifts in on this edge
    assign load_done_o = cmd_i.load_en && (load_cnt == CNT_W'(`KEY_RAM_WORDS + 1));

endmodule

//--- design/cascade_ctrl.sv
// ----------------------------------------------------------------------
// cascade controller, sequences key load, packet replies and frame end
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "cascade_settings.svh"

module cascade_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    input  logic                      load_done_i,
    input  logic                      b2a_valid_i,
    input  cascade_pkg::cascade_hdr_t b2a_data_i,
    input  logic                      round_clean_i,
    output logic                      b2a_rd_en_o,
    output cascade_pkg::ctrl_cmd_t    cmd_o,
    output cascade_pkg::cascade_hdr_t hdr_o,
    output logic [`HDR_CNT_W-1:0]     word_idx_o,
    output logic                      frame_valid_o,
    output logic                      cascade_done_o
);

    cascade_pkg::ctrl_state_e  state;
    cascade_pkg::ctrl_state_e  next_state;
    cascade_pkg::cascade_hdr_t hdr_q;
    logic [`HDR_CNT_W-1:0]     reply_cnt;
    logic                      frame_end;

    // a clean first top-level round closes the frame
    assign frame_end = (hdr_q.ptype == cascade_pkg::PT_FIRST_TOP) && round_clean_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= cascade_pkg::CASCADE_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cascade_pkg::CASCADE_IDLE: if (start_i) next_state = cascade_pkg::LOADKEY;
            cascade_pkg::LOADKEY:      if (load_done_i) next_state = cascade_pkg::IDLE;
            cascade_pkg::IDLE:         if (b2a_valid_i) next_state = cascade_pkg::READ_HEADER;
            cascade_pkg::READ_HEADER:  next_state = cascade_pkg::WRITE_HEADER;
            cascade_pkg::WRITE_HEADER: begin
                next_state = (hdr_q.count == '0) ? cascade_pkg::SETTLE : cascade_pkg::REPLY;
            end
            cascade_pkg::REPLY:        if (reply_cnt == hdr_q.count) next_state = cascade_pkg::SETTLE;
            // lets the last popcount reach the round total
            cascade_pkg::SETTLE:       next_state = cascade_pkg::CLOSE;
            cascade_pkg::CLOSE:        next_state = cascade_pkg::FINISH;
            cascade_pkg::FINISH: begin
                next_state = frame_end ? cascade_pkg::FRAME_OUT : cascade_pkg::IDLE;
            end
            cascade_pkg::FRAME_OUT:    next_state = cascade_pkg::CASCADE_END;
            default:                   next_state = cascade_pkg::CASCADE_IDLE;
        endcase
    end

    always_comb begin
        cmd_o             = '0;
        cmd_o.load_en     = (state == cascade_pkg::LOADKEY);
        cmd_o.read_hdr    = (state == cascade_pkg::READ_HEADER);
        cmd_o.write_hdr   = (state == cascade_pkg::WRITE_HEADER);
        cmd_o.reply_en    = (state == cascade_pkg::REPLY);
        cmd_o.close_hdr   = (state == cascade_pkg::CLOSE) && hdr_q.ptype[2];
        cmd_o.clear_round = (state == cascade_pkg::CASCADE_END);
    end

    // header pop, then one pop per reply word
    assign b2a_rd_en_o = cmd_o.read_hdr || cmd_o.reply_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdr_q <= '0;
        end else if (cmd_o.read_hdr) begin
            hdr_q <= b2a_data_i;
        end
    end

    // runs one ahead of the word being popped, parity lookup is registered
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reply_cnt <= '0;
        end else if (cmd_o.read_hdr) begin
            reply_cnt <= '0;
        end else if (cmd_o.write_hdr || cmd_o.reply_en) begin
            reply_cnt <= reply_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_valid_o  <= 1'b0;
            cascade_done_o <= 1'b0;
        end else begin
            frame_valid_o  <= (state == cascade_pkg::FINISH) && frame_end;
            cascade_done_o <= (state == cascade_pkg::FRAME_OUT);
        end
    end

    assign hdr_o      = hdr_q;
    assign word_idx_o = reply_cnt;

endmodule

//--- design/reply/parity_word_sel.sv
// ----------------------------------------------------------------------
// parity tree over the frame key and registered reply word select
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "cascade_settings.svh"

module parity_word_sel (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`KEY_LEN-1:0]    frame_key_i,
    input  logic [3:0]             tree_row_i,
    input  logic [`HDR_CNT_W-1:0]  word_idx_i,
    output logic [`FIFO_W-1:0]     parity_word_o
);

    wire  [`KEY_LEN-1:0] rows [1:`TREE_ROWS];
    logic [`KEY_LEN-1:0] row_sel;
    logic [`KEY_LEN-1:0] word_shift;

    assign rows[1] = frame_key_i;

    // each row halves the one above, kept packed at the msb end
    for (genvar r = 2; r <= `TREE_ROWS; r++) begin : g_row
        localparam int W = `KEY_LEN >> (r - 1);
        for (genvar i = 0; i < W; i++) begin : g_bit
            assign rows[r][`KEY_LEN-W+i] = rows[r-1][`KEY_LEN-2*W+2*i]
                                         ^ rows[r-1][`KEY_LEN-2*W+2*i+1];
        end
        assign rows[r][`KEY_LEN-W-1:0] = '0;
    end

    // unknown rows give all zero
    always_comb begin
        row_sel = '0;
        for (int r = 1; r <= `TREE_ROWS; r++) begin
            if (tree_row_i == 4'(r)) begin
                row_sel = rows[r];
            end
        end
    end

    assign word_shift = row_sel << (word_idx_i * `FIFO_W);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            parity_word_o <= '0;
        end else begin
            parity_word_o <= word_shift[`KEY_LEN-1 -: `FIFO_W];
        end
    end

endmodule

//--- design/reply/error_tally.sv
// ----------------------------------------------------------------------
// top-level mismatch count, per round and per frame
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "cascade_settings.svh"

module error_tally (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cascade_pkg::ctrl_cmd_t cmd_i,
    input  logic                   top_i,
    input  logic [`FIFO_W-1:0]     mine_i,
    input  logic [`FIFO_W-1:0]     theirs_i,
    output logic [`ERR_W-1:0]      round_errors_o,
    output logic                   round_clean_o,
    output logic [`ERR_W-1:0]      frame_error_count_o
);

    localparam int POP_W = $clog2(`FIFO_W + 1);

    logic [`FIFO_W-1:0] diff;
    logic [POP_W-1:0]   ones;
    logic [POP_W-1:0]   pop_q;
    logic               pop_v;

    assign diff = mine_i ^ theirs_i;

    always_comb begin
        ones = '0;
        for (int i = 0; i < `FIFO_W; i++) begin
            ones = ones + POP_W'(diff[i]);
        end
    end

    // xor stage registered before the add
    always_ff @(posedge clk) begin
        pop_q <= ones;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pop_v               <= 1'b0;
            round_errors_o      <= '0;
            frame_error_count_o <= '0;
        end else begin
            pop_v <= cmd_i.reply_en && top_i;
            if (cmd_i.read_hdr || cmd_i.clear_round) begin
                round_errors_o <= '0;
            end else if (pop_v) begin
                round_errors_o <= round_errors_o + `ERR_W'(pop_q);
            end
            if (cmd_i.clear_round) begin
                frame_error_count_o <= '0;
            end else if (cmd_i.close_hdr && top_i) begin
                frame_error_count_o <= frame_error_count_o + round_errors_o;
            end
        end
    end

    assign round_clean_o = (round_errors_o == '0);

endmodule

//--- design/reply/a2b_writer.sv
// ----------------------------------------------------------------------
// reply writer, headers and parity words onto the A2B FIFO
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "cascade_settings.svh"

module a2b_writer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cascade_pkg::ctrl_cmd_t    cmd_i,
    input  cascade_pkg::cascade_hdr_t hdr_i,
    input  logic [`FIFO_W-1:0]        mask_i,
    input  logic [`FIFO_W-1:0]        parity_word_i,
    input  logic                      round_clean_i,
    output logic                      a2b_wr_en_o,
    output logic [`FIFO_W-1:0]        a2b_data_o
);

    cascade_pkg::cascade_hdr_t open_word;
    cascade_pkg::cascade_hdr_t close_word;
    logic [`FIFO_W-1:0]        body_word;
    logic                      top;

    assign top = hdr_i.ptype[2];

    always_comb begin
        open_word     = hdr_i;
        open_word.msg = cascade_pkg::MSG_A2B_PARITY;
        // top level: Alice's own words plus a closing header
        if (top) begin
            open_word.ptype = cascade_pkg::PT_TOP_COMPARE;
            open_word.count = hdr_i.count + 1'b1;
        end

        close_word     = hdr_i;
        close_word.msg = cascade_pkg::MSG_A2B_PARITY;
        if (round_clean_i) begin
            close_word.ptype = cascade_pkg::PT_TOP_CORRECT;
            close_word.count = '0;
        end else begin
            close_word.ptype = cascade_pkg::PT_TOP_MESSAGE;
        end

        // normal rounds only answer the blocks Bob asked for
        body_word = top ? parity_word_i : (parity_word_i & mask_i);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a2b_wr_en_o <= 1'b0;
        end else begin
            a2b_wr_en_o <= cmd_i.write_hdr || cmd_i.close_hdr || cmd_i.reply_en;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_i.write_hdr) begin
            a2b_data_o <= open_word;
        end else if (cmd_i.close_hdr) begin
            a2b_data_o <= close_word;
        end else if (cmd_i.reply_en) begin
            a2b_data_o <= body_word;
        end
    end

endmodule

//--- design/alice_cascade_top.sv
// ----------------------------------------------------------------------
// Alice side of cascade reconciliation, answers Bob's parity requests
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "cascade_settings.svh"

module alice_cascade_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  logic [`ROUND_W-1:0]    frame_round_i,
    input  logic                   addr_bank_i,
    output logic [`RAM_ADDR_W-1:0] key_addr_o,
    input  logic [`RAM_W-1:0]      key_data_i,
    input  logic                   b2a_valid_i,
    input  logic [`FIFO_W-1:0]     b2a_data_i,
    output logic                   b2a_rd_en_o,
    output logic                   a2b_wr_en_o,
    output logic [`FIFO_W-1:0]     a2b_data_o,
    output logic [`ERR_W-1:0]      frame_error_count_o,
    output logic                   frame_valid_o,
    output logic                   cascade_done_o,
    output logic [`KEY_LEN-1:0]    frame_key_o
);

    cascade_pkg::ctrl_cmd_t    cmd;
    cascade_pkg::cascade_hdr_t hdr;
    logic                      load_done;
    logic [`HDR_CNT_W-1:0]     word_idx;
    logic [`FIFO_W-1:0]        parity_word;
    logic                      round_clean;

    // input side
    key_loader u_key_loader (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_i         (cmd),
        .frame_round_i (frame_round_i),
        .addr_bank_i   (addr_bank_i),
        .key_addr_o    (key_addr_o),
        .key_data_i    (key_data_i),
        .load_done_o   (load_done),
        .frame_key_o   (frame_key_o)
    );

    cascade_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .load_done_i    (load_done),
        .b2a_valid_i    (b2a_valid_i),
        .b2a_data_i     (b2a_data_i),
        .round_clean_i  (round_clean),
        .b2a_rd_en_o    (b2a_rd_en_o),
        .cmd_o          (cmd),
        .hdr_o          (hdr),
        .word_idx_o     (word_idx),
        .frame_valid_o  (frame_valid_o),
        .cascade_done_o (cascade_done_o)
    );

    parity_word_sel u_parity (
        .clk           (clk),
        .rst_n         (rst_n),
        .frame_key_i   (frame_key_o),
        .tree_row_i    (hdr.tree_row),
        .word_idx_i    (word_idx),
        .parity_word_o (parity_word)
    );

    // per-round count only feeds the clean flag here
    error_tally u_tally (
        .clk                 (clk),
        .rst_n               (rst_n),
        .cmd_i               (cmd),
        .top_i               (hdr.ptype[2]),
        .mine_i              (parity_word),
        .theirs_i            (b2a_data_i),
        .round_errors_o      (),
        .round_clean_o       (round_clean),
        .frame_error_count_o (frame_error_count_o)
    );

    // output side
    a2b_writer u_writer (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_i         (cmd),
        .hdr_i         (hdr),
        .mask_i        (b2a_data_i),
        .parity_word_i (parity_word),
        .round_clean_i (round_clean),
        .a2b_wr_en_o   (a2b_wr_en_o),
        .a2b_data_o    (a2b_data_o)
    );

endmodule

//--- bench/alice_cascade_sva.sv
// ----------------------------------------------------------------------
// controller and FIFO strobe assertions, bound into cascade_ctrl
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module alice_cascade_sva (
    input logic                     clk,
    input logic                     rst_n,
    input cascade_pkg::ctrl_state_e state_i,
    input logic                     b2a_valid_i,
    input logic                     b2a_rd_en_i,
    input logic                     tx_strobe_i,
    input logic                     frame_valid_i,
    input logic                     cascade_done_i
);

    a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n)
        b2a_rd_en_i |-> b2a_valid_i)
        else $error("receive FIFO popped while empty");

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid_i |=> !frame_valid_i)
        else $error("frame_valid longer than one cycle");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        cascade_done_i |=> !cascade_done_i)
        else $error("cascade_done longer than one cycle");

    a_done_order: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid_i |=> cascade_done_i)
        else $error("cascade_done did not follow frame_valid");

    // transmit write enable is these strobes one cycle later
    a_quiet_load: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == cascade_pkg::LOADKEY) |-> !$past(tx_strobe_i))
        else $error("transmit write during key load");

endmodule

//--- bench/tb_alice_cascade.sv
// ----------------------------------------------------------------------
// testbench for the Alice cascade top with RAM and FIFO models and checks
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "cascade_settings.svh"

module tb_alice_cascade;

    localparam int NROWS = 7;

    typedef struct packed {
        logic [2:0] ptype;
        logic [3:0] tree_row;
        logic [8:0] count;
        logic [5:0] flips;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   start_i;
    logic [`ROUND_W-1:0]    frame_round_i;
    logic                   addr_bank_i;
    logic [`RAM_ADDR_W-1:0] key_addr_o;
    logic [`RAM_W-1:0]      key_data_i;
    logic                   b2a_valid_i;
    logic [`FIFO_W-1:0]     b2a_data_i;
    logic                   b2a_rd_en_o;
    logic                   a2b_wr_en_o;
    logic [`FIFO_W-1:0]     a2b_data_o;
    logic [`ERR_W-1:0]      frame_error_count_o;
    logic                   frame_valid_o;
    logic                   cascade_done_o;
    logic [`KEY_LEN-1:0]    frame_key_o;

    logic [`RAM_W-1:0]  mem [0:(1<<`RAM_ADDR_W)-1];
    logic [`FIFO_W-1:0] rx_q [$];
    logic [`FIFO_W-1:0] tx_q [$];
    logic [`KEY_LEN-1:0] key;
    logic [15:0]        lfsr_q;
    row_t               table_q [NROWS];
    int                 errors;
    int                 checks;
    int                 exp_total;
    int                 fv_pulses;

    alice_cascade_top UUT (.*);

    bind cascade_ctrl alice_cascade_sva u_sva (
        .clk            (clk),
        .rst_n          (rst_n),
        .state_i        (state),
        .b2a_valid_i    (b2a_valid_i),
        .b2a_rd_en_i    (b2a_rd_en_o),
        .tx_strobe_i    (cmd_o.write_hdr || cmd_o.close_hdr || cmd_o.reply_en),
        .frame_valid_i  (frame_valid_o),
        .cascade_done_i (cascade_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // sifted-key RAM with one cycle read latency
    always @(posedge clk) begin
        key_data_i <= mem[key_addr_o];
    end

    // show-ahead receive FIFO
    always @(posedge clk) begin
        if (b2a_rd_en_o && rx_q.size() > 0) begin
            void'(rx_q.pop_front());
        end
        b2a_valid_i <= (rx_q.size() > 0);
        b2a_data_i  <= (rx_q.size() > 0) ? rx_q[0] : '0;
    end

    always @(posedge clk) begin
        if (a2b_wr_en_o) begin
            tx_q.push_back(a2b_data_o);
        end
    end

    always @(negedge clk) begin
        if (frame_valid_o) begin
            fv_pulses++;
        end
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r = {r[62:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // pairwise XOR folds with the result moved to the top of the field
    function automatic logic [`KEY_LEN-1:0] parity_row(input logic [`KEY_LEN-1:0] k,
                                                       input int row);
        logic [`KEY_LEN-1:0] cur;
        int                  w;
        cur = k;
        w = `KEY_LEN;
        for (int s = 1; s < row; s++) begin
            for (int i = 0; i < w / 2; i++) begin
                cur[i] = cur[2*i] ^ cur[2*i+1];
            end
            w = w / 2;
        end
        return cur << (`KEY_LEN - w);
    endfunction

    task automatic run_packet(input int idx);
        row_t                      r;
        cascade_pkg::cascade_hdr_t req;
        cascade_pkg::cascade_hdr_t rsp;
        logic [`KEY_LEN-1:0]       prow;
        logic [`FIFO_W-1:0]        word;
        logic [`FIFO_W-1:0]        bob;
        logic [`FIFO_W-1:0]        flip_mask;
        logic [`FIFO_W-1:0]        exp_q [$];
        int                        waited;
        r = table_q[idx];
        prow = parity_row(key, int'(r.tree_row));
        flip_mask = (r.flips == 0) ? '0 : (32'hFFFF_FFFF >> (32 - int'(r.flips)));
        req = '0;
        req.msg = cascade_pkg::MSG_B2A_ASK;
        req.len_code = 4'h3;
        req.count = r.count;
        req.ptype = r.ptype;
        req.shuffle_set = 3'(idx);
        req.tree_row = r.tree_row;
        req.frame_id = 5'(idx + 1);
        rsp = req;
        rsp.msg = cascade_pkg::MSG_A2B_PARITY;
        if (r.ptype[2]) begin
            rsp.ptype = cascade_pkg::PT_TOP_COMPARE;
            rsp.count = r.count + 1'b1;
        end
        @(negedge clk);
        rx_q.push_back(req);
        exp_q.push_back(rsp);
        for (int k = 0; k < int'(r.count); k++) begin
            word = prow[`KEY_LEN-1-32*k -: 32];
            if (r.ptype[2]) begin
                // mismatches sit in the last word of the round
                bob = (k == int'(r.count) - 1) ? (word ^ flip_mask) : word;
                exp_q.push_back(word);
            end else begin
                bob = 32'(random_bits(32));
                exp_q.push_back(word & bob);
            end
            rx_q.push_back(bob);
        end
        if (r.ptype[2]) begin
            rsp = req;
            rsp.msg = cascade_pkg::MSG_A2B_PARITY;
            rsp.ptype = (r.flips == 0) ? cascade_pkg::PT_TOP_CORRECT
                                       : cascade_pkg::PT_TOP_MESSAGE;
            if (r.flips == 0) begin
                rsp.count = '0;
            end
            exp_q.push_back(rsp);
            exp_total += int'(r.flips);
        end
        waited = 0;
        while (tx_q.size() < exp_q.size() && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (tx_q.size() != exp_q.size()) begin
            errors++;
            $display("reply to packet %0d has %0d words instead of %0d",
                     idx, tx_q.size(), exp_q.size());
        end else begin
            for (int i = 0; i < exp_q.size(); i++) begin
                checks++;
                if (tx_q[i] !== exp_q[i]) begin
                    errors++;
                    $display("Fail %0t: packet %0d word %0d is %h, expected %h",
                             $time, idx, i, tx_q[i], exp_q[i]);
                end
            end
        end
        tx_q.delete();
        checks++;
        if (int'(frame_error_count_o) != exp_total) begin
            errors++;
            $display("Fail %0t: frame errors %0d after packet %0d, expected %0d",
                     $time, frame_error_count_o, idx, exp_total);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        start_i = 1'b0;
        frame_round_i = 12'h0a3;
        addr_bank_i = 1'b1;
        key_data_i = '0;
        b2a_valid_i = 1'b0;
        b2a_data_i = '0;
        errors = 0;
        checks = 0;
        exp_total = 0;
        fv_pulses = 0;
        lfsr_q = 16'd46;
        table_q = '{
            '{3'b000, 4'd1, 9'd4, 6'd0},
            '{3'b000, 4'd3, 9'd2, 6'd0},
            '{3'b100, 4'd2, 9'd4, 6'd3},
            '{3'b101, 4'd4, 9'd1, 6'd2},
            '{3'b000, 4'd2, 9'd3, 6'd0},
            '{3'b100, 4'd1, 9'd8, 6'd0},
            '{3'b101, 4'd2, 9'd2, 6'd0}
        };
        for (int a = 0; a < (1 << `RAM_ADDR_W); a++) begin
            mem[a] = {16'(a), ~16'(a), 16'(a) ^ 16'h5a5a, 16'(a) + 16'h1234};
        end
        // frame words sit at bank, round, word index
        for (int j = 0; j < `KEY_RAM_WORDS; j++) begin
            mem[{1'b1, 12'h0a3, 2'(j)}] = random_bits(64);
            key[`KEY_LEN-1-64*j -: 64] = mem[{1'b1, 12'h0a3, 2'(j)}];
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        repeat (`KEY_RAM_WORDS + 4) @(negedge clk);
        checks++;
        if (frame_key_o !== key) begin
            errors++;
            $display("Fail %0t: frame key %h, expected %h", $time, frame_key_o, key);
        end
        for (int i = 0; i < NROWS; i++) begin
            run_packet(i);
            repeat (3) @(negedge clk);
        end
        checks += 2;
        if (fv_pulses != 1) begin
            errors++;
            $display("Fail %0t: %0d frame-valid pulses, expected 1", $time, fv_pulses);
        end
        if (cascade_done_o !== 1'b0 || frame_error_count_o !== '0) begin
            errors++;
            $display("Fail %0t: done %b total %0d after frame end, expected 0 and 0",
                     $time, cascade_done_o, frame_error_count_o);
        end
        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // the frame-end pulse pair and the total held at frame_valid
    initial begin
        @(posedge frame_valid_o);
        @(negedge clk);
        checks++;
        if (int'(frame_error_count_o) != exp_total) begin
            errors++;
            $display("Fail %0t: frame total %0d at frame end, expected %0d",
                     $time, frame_error_count_o, exp_total);
        end
        @(negedge clk);
        checks++;
        if (cascade_done_o !== 1'b1 || frame_valid_o !== 1'b0) begin
            errors++;
            $display("Fail %0t: done %b valid %b one cycle after frame valid",
                     $time, cascade_done_o, frame_valid_o);
        end
    end

    initial begin
        repeat (NROWS * 200) @(posedge clk);
        $display("watchdog expired before the test sequence ended");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+common
common/cascade_pkg.sv
design/key_loader.sv
design/cascade_ctrl.sv
design/reply/parity_word_sel.sv
design/reply/error_tally.sv
design/reply/a2b_writer.sv
design/alice_cascade_top.sv
bench/alice_cascade_sva.sv
bench/tb_alice_cascade.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_alice_cascade
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
